// File: lsu_pkg.sv
package lsu_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  parameter int XLEN        = 64;
  parameter int ADDR_W      = 32;
  parameter int CMT_ID_W    = 6;
  parameter int DWORD_BYTES = 8;
  parameter int DW_OFS_W    = $clog2(DWORD_BYTES);

  typedef logic [XLEN-1:0]        xlen_t;
  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [CMT_ID_W-1:0]    cmt_id_t;
  typedef logic [31:0]            inst_t;
  typedef logic [DWORD_BYTES-1:0] byte_en_t;
  typedef logic [4:0]             reg_idx_t;

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------
  typedef enum logic [2:0] {
    OP_NONE,
    OP_LOAD,
    OP_STORE,
    OP_FENCE,
    OP_FENCE_I,
    OP_ILLEGAL
  } mem_op_t;

  typedef enum logic [1:0] {
    SIZE_B,
    SIZE_H,
    SIZE_W,
    SIZE_DW
  } mem_size_t;

  typedef enum logic [1:0] {
    EXC_NONE,
    EXC_LOAD_MISALIGN,
    EXC_STORE_MISALIGN,
    EXC_ILLEGAL_INST
  } except_t;

  // --------------------------------------------------
  // Bundles
  // --------------------------------------------------
  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
    inst_t   inst;
    xlen_t   rs1_data;
    xlen_t   rs2_data;
  } lsu_issue_t;

  typedef struct packed {
    mem_op_t   op;
    mem_size_t size;
    logic      is_signed;
    xlen_t     imm;
    reg_idx_t  rd;
  } lsu_ctrl_t;

  // Address is always doubleword aligned
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } rd_req_t;

  // Data and byte enables already placed on their lanes
  typedef struct packed {
    addr_t    addr;
    byte_en_t byte_en;
    xlen_t    data;
  } st_entry_t;

  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
    logic    except_valid;
    except_t except_type;
    xlen_t   tval;
  } done_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    xlen_t    data;
  } rf_wr_t;

  typedef struct packed {
    addr_t    adr;
    xlen_t    dat;
    byte_en_t sel;
  } dm_wr_t;

endpackage

// File: lsu_decoder.sv
`timescale 1ns/1ps

module lsu_decoder (
  input  lsu_pkg::inst_t     i_inst,
  output lsu_pkg::lsu_ctrl_t o_ctrl
);

  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;

  logic [6:0] w_opcode;
  logic [2:0] w_funct3;

  assign w_opcode = i_inst[6:0];
  assign w_funct3 = i_inst[14:12];

  always_comb begin
    o_ctrl.op        = lsu_pkg::OP_ILLEGAL;
    o_ctrl.size      = lsu_pkg::mem_size_t'(w_funct3[1:0]);
    o_ctrl.is_signed = ~w_funct3[2];
    // I-type immediate by default
    o_ctrl.imm       = {{52{i_inst[31]}}, i_inst[31:20]};
    o_ctrl.rd        = '0;
    case (w_opcode)
      OPC_LOAD: begin
        // funct3 111 has no load
        if (w_funct3 != 3'b111) begin
          o_ctrl.op = lsu_pkg::OP_LOAD;
          o_ctrl.rd = i_inst[11:7];
        end
      end
      OPC_STORE: begin
        if (!w_funct3[2]) begin
          o_ctrl.op = lsu_pkg::OP_STORE;
        end
        o_ctrl.imm = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
      end
      OPC_MISC_MEM: begin
        if (w_funct3 == 3'b000) begin
          o_ctrl.op = lsu_pkg::OP_FENCE;
        end else if (w_funct3 == 3'b001) begin
          o_ctrl.op = lsu_pkg::OP_FENCE_I;
        end
      end
      default: begin
        o_ctrl.op = lsu_pkg::OP_ILLEGAL;
      end
    endcase
  end

endmodule

// File: lsu_agu.sv
`timescale 1ns/1ps

module lsu_agu (
  input  logic               i_valid,
  input  lsu_pkg::lsu_ctrl_t i_ctrl,
  input  lsu_pkg::xlen_t     i_rs1,
  output lsu_pkg::addr_t     o_addr,
  output lsu_pkg::except_t   o_except,
  output lsu_pkg::rd_req_t   o_rd_req
);

  logic w_misalign;

  // Physical address, upper bits of rs1 are ignored
  assign o_addr = i_rs1[lsu_pkg::ADDR_W-1:0] + i_ctrl.imm[lsu_pkg::ADDR_W-1:0];

  always_comb begin
    case (i_ctrl.size)
      lsu_pkg::SIZE_H:  w_misalign = o_addr[0];
      lsu_pkg::SIZE_W:  w_misalign = |o_addr[1:0];
      lsu_pkg::SIZE_DW: w_misalign = |o_addr[2:0];
      default:          w_misalign = 1'b0;
    endcase
  end

  always_comb begin
    o_except = lsu_pkg::EXC_NONE;
    if (i_ctrl.op == lsu_pkg::OP_ILLEGAL) begin
      o_except = lsu_pkg::EXC_ILLEGAL_INST;
    end else if (w_misalign && (i_ctrl.op == lsu_pkg::OP_LOAD)) begin
      o_except = lsu_pkg::EXC_LOAD_MISALIGN;
    end else if (w_misalign && (i_ctrl.op == lsu_pkg::OP_STORE)) begin
      o_except = lsu_pkg::EXC_STORE_MISALIGN;
    end
  end

  // Doubleword read, data comes back in the next cycle
  assign o_rd_req.valid = i_valid && (i_ctrl.op == lsu_pkg::OP_LOAD) &&
                          (o_except == lsu_pkg::EXC_NONE);
  assign o_rd_req.addr  = {o_addr[lsu_pkg::ADDR_W-1:lsu_pkg::DW_OFS_W],
                           {lsu_pkg::DW_OFS_W{1'b0}}};

endmodule

// File: lsu_load_align.sv
`timescale 1ns/1ps

module lsu_load_align (
  input  lsu_pkg::lsu_ctrl_t i_ctrl,
  input  lsu_pkg::addr_t     i_addr,
  input  lsu_pkg::xlen_t     i_mem_data,
  input  lsu_pkg::byte_en_t  i_fwd_en,
  input  lsu_pkg::xlen_t     i_fwd_data,
  output lsu_pkg::xlen_t     o_data
);

  lsu_pkg::xlen_t w_merged;
  lsu_pkg::xlen_t w_shifted;

  // --------------------------------------------------
  // Lane merge
  // --------------------------------------------------
  always_comb begin
    for (int b = 0; b < lsu_pkg::DWORD_BYTES; b++) begin
      if (i_fwd_en[b]) begin
        w_merged[b*8 +: 8] = i_fwd_data[b*8 +: 8];
      end else begin
        w_merged[b*8 +: 8] = i_mem_data[b*8 +: 8];
      end
    end
  end

  // Bring the addressed byte down to lane 0
  assign w_shifted = w_merged >> {i_addr[lsu_pkg::DW_OFS_W-1:0], 3'b000};

  // --------------------------------------------------
  // Size and extension
  // --------------------------------------------------
  always_comb begin
    case (i_ctrl.size)
      lsu_pkg::SIZE_B: begin
        if (i_ctrl.is_signed) begin
          o_data = {{56{w_shifted[7]}}, w_shifted[7:0]};
        end else begin
          o_data = {56'h0, w_shifted[7:0]};
        end
      end
      lsu_pkg::SIZE_H: begin
        if (i_ctrl.is_signed) begin
          o_data = {{48{w_shifted[15]}}, w_shifted[15:0]};
        end else begin
          o_data = {48'h0, w_shifted[15:0]};
        end
      end
      lsu_pkg::SIZE_W: begin
        if (i_ctrl.is_signed) begin
          o_data = {{32{w_shifted[31]}}, w_shifted[31:0]};
        end else begin
          o_data = {32'h0, w_shifted[31:0]};
        end
      end
      default: begin
        o_data = w_shifted;
      end
    endcase
  end

endmodule

// File: lsu_store_buffer.sv
`timescale 1ns/1ps

module lsu_store_buffer #(
  parameter int SB_DEPTH = 4
) (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_push,
  input  lsu_pkg::st_entry_t  i_entry,
  input  lsu_pkg::addr_t      i_fwd_addr,
  output lsu_pkg::byte_en_t   o_fwd_en,
  output lsu_pkg::xlen_t      o_fwd_data,
  output logic                o_space_ok,
  output logic                o_dm_cyc,
  output logic                o_dm_stb,
  output logic                o_dm_we,
  output lsu_pkg::dm_wr_t     o_dm_wr,
  input  logic                i_dm_ack
);

  localparam int CNT_W = $clog2(SB_DEPTH + 1);
  // New op plus stores that may sit in EX1 and EX2
  localparam int SPACE_NEED = 3;

  // Entry 0 is the oldest store
  lsu_pkg::st_entry_t r_entries [SB_DEPTH];
  logic [CNT_W-1:0]   r_count;
  logic [CNT_W-1:0]   w_push_idx;
  logic               w_busy;
  logic               w_pop;

  assign w_busy     = (r_count != '0);
  assign w_pop      = w_busy && i_dm_ack;
  assign w_push_idx = w_pop ? (r_count - 1'b1) : r_count;
  assign o_space_ok = ((CNT_W'(SB_DEPTH) - r_count) >= CNT_W'(SPACE_NEED));

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_count <= '0;
    end else begin
      r_count <= r_count + CNT_W'(i_push) - CNT_W'(w_pop);
    end
  end

  // Shift on pop, younger entries move one slot toward the head
  always_ff @(posedge i_clk) begin
    for (int i = 0; i < SB_DEPTH; i++) begin
      if (i_push && (CNT_W'(i) == w_push_idx)) begin
        r_entries[i] <= i_entry;
      end else if (w_pop && (i < SB_DEPTH - 1)) begin
        r_entries[i] <= r_entries[i+1];
      end
    end
  end

  // --------------------------------------------------
  // Forwarding lookup
  // --------------------------------------------------
  // Walk oldest to youngest so younger bytes win
  always_comb begin
    o_fwd_en   = '0;
    o_fwd_data = '0;
    for (int i = 0; i < SB_DEPTH; i++) begin
      if ((CNT_W'(i) < r_count) &&
          (r_entries[i].addr[lsu_pkg::ADDR_W-1:lsu_pkg::DW_OFS_W] ==
           i_fwd_addr[lsu_pkg::ADDR_W-1:lsu_pkg::DW_OFS_W])) begin
        for (int b = 0; b < lsu_pkg::DWORD_BYTES; b++) begin
          if (r_entries[i].byte_en[b]) begin
            o_fwd_en[b]          = 1'b1;
            o_fwd_data[b*8 +: 8] = r_entries[i].data[b*8 +: 8];
          end
        end
      end
    end
  end

  // --------------------------------------------------
  // Wishbone drain
  // --------------------------------------------------
  assign o_dm_cyc    = w_busy;
  assign o_dm_stb    = w_busy;
  assign o_dm_we     = w_busy;
  assign o_dm_wr.adr = r_entries[0].addr;
  assign o_dm_wr.dat = r_entries[0].data;
  assign o_dm_wr.sel = r_entries[0].byte_en;

  a_no_push_full: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_push |-> (r_count != CNT_W'(SB_DEPTH))
  );

  a_drain_stable: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (o_dm_stb && !i_dm_ack) |=> (o_dm_stb && $stable(o_dm_wr))
  );

endmodule

// File: lsu_fence_i_wait.sv
`timescale 1ns/1ps

module lsu_fence_i_wait (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_done_fence_i,
  input  lsu_pkg::cmt_id_t i_cmt_id,
  input  logic             i_commit_valid,
  input  lsu_pkg::cmt_id_t i_commit_id,
  output logic             o_fence_i
);

  logic             r_wait;
  lsu_pkg::cmt_id_t r_cmt_id;
  logic             w_match;

  assign w_match   = r_wait && i_commit_valid && (i_commit_id == r_cmt_id);
  assign o_fence_i = w_match;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wait <= 1'b0;
    end else if (i_done_fence_i) begin
      r_wait <= 1'b1;
    end else if (w_match) begin
      r_wait <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_done_fence_i) begin
      r_cmt_id <= i_cmt_id;
    end
  end

  a_single_wait: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_done_fence_i |-> (!r_wait || w_match)
  );

endmodule

// File: lsu_pipe.sv
`timescale 1ns/1ps

module lsu_pipe #(
  parameter int SB_DEPTH = 4
) (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  lsu_pkg::lsu_issue_t i_issue,
  output logic                o_issue_ready,
  input  logic                i_flush,
  input  logic                i_commit_valid,
  input  lsu_pkg::cmt_id_t    i_commit_id,
  output lsu_pkg::rd_req_t    o_rd_req,
  input  lsu_pkg::xlen_t      i_rd_data,
  output logic                o_dm_cyc,
  output logic                o_dm_stb,
  output logic                o_dm_we,
  output lsu_pkg::dm_wr_t     o_dm_wr,
  input  logic                i_dm_ack,
  output lsu_pkg::done_t      o_done,
  output lsu_pkg::rf_wr_t     o_rf_wr,
  output logic                o_fence_i
);

  // EX0
  lsu_pkg::lsu_ctrl_t w_ex0_ctrl;
  logic               w_ex0_fire;
  // EX1
  logic               r_ex1_valid;
  lsu_pkg::cmt_id_t   r_ex1_cmt_id;
  lsu_pkg::lsu_ctrl_t r_ex1_ctrl;
  lsu_pkg::xlen_t     r_ex1_rs1;
  lsu_pkg::xlen_t     r_ex1_rs2;
  lsu_pkg::addr_t     w_ex1_addr;
  lsu_pkg::except_t   w_ex1_except;
  // EX2
  logic               r_ex2_valid;
  lsu_pkg::cmt_id_t   r_ex2_cmt_id;
  lsu_pkg::lsu_ctrl_t r_ex2_ctrl;
  lsu_pkg::addr_t     r_ex2_addr;
  lsu_pkg::except_t   r_ex2_except;
  lsu_pkg::xlen_t     r_ex2_rs2;
  lsu_pkg::byte_en_t  w_ex2_fwd_en;
  lsu_pkg::xlen_t     w_ex2_fwd_data;
  lsu_pkg::xlen_t     w_ex2_load_data;
  lsu_pkg::byte_en_t  w_ex2_size_mask;
  lsu_pkg::st_entry_t w_ex2_st_entry;
  logic               w_ex2_push;
  // EX3
  logic               r_ex3_valid;
  lsu_pkg::cmt_id_t   r_ex3_cmt_id;
  lsu_pkg::lsu_ctrl_t r_ex3_ctrl;
  lsu_pkg::addr_t     r_ex3_addr;
  lsu_pkg::except_t   r_ex3_except;
  lsu_pkg::xlen_t     r_ex3_data;

  // --------------------------------------------------
  // Stage valids, flush kills EX0 to EX2
  // --------------------------------------------------
  assign w_ex0_fire = i_issue.valid && o_issue_ready && !i_flush;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid <= 1'b0;
      r_ex2_valid <= 1'b0;
      r_ex3_valid <= 1'b0;
    end else begin
      r_ex1_valid <= w_ex0_fire;
      r_ex2_valid <= r_ex1_valid && !i_flush;
      r_ex3_valid <= r_ex2_valid && !i_flush;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1_cmt_id <= i_issue.cmt_id;
    r_ex1_ctrl   <= w_ex0_ctrl;
    r_ex1_rs1    <= i_issue.rs1_data;
    r_ex1_rs2    <= i_issue.rs2_data;
    r_ex2_cmt_id <= r_ex1_cmt_id;
    r_ex2_ctrl   <= r_ex1_ctrl;
    r_ex2_addr   <= w_ex1_addr;
    r_ex2_except <= w_ex1_except;
    r_ex2_rs2    <= r_ex1_rs2;
    r_ex3_cmt_id <= r_ex2_cmt_id;
    r_ex3_ctrl   <= r_ex2_ctrl;
    r_ex3_addr   <= r_ex2_addr;
    r_ex3_except <= r_ex2_except;
    r_ex3_data   <= w_ex2_load_data;
  end

  lsu_decoder u_decoder (
    .i_inst (i_issue.inst),
    .o_ctrl (w_ex0_ctrl)
  );

  lsu_agu u_agu (
    .i_valid  (r_ex1_valid),
    .i_ctrl   (r_ex1_ctrl),
    .i_rs1    (r_ex1_rs1),
    .o_addr   (w_ex1_addr),
    .o_except (w_ex1_except),
    .o_rd_req (o_rd_req)
  );

  lsu_load_align u_load_align (
    .i_ctrl     (r_ex2_ctrl),
    .i_addr     (r_ex2_addr),
    .i_mem_data (i_rd_data),
    .i_fwd_en   (w_ex2_fwd_en),
    .i_fwd_data (w_ex2_fwd_data),
    .o_data     (w_ex2_load_data)
  );

  // --------------------------------------------------
  // EX2 store lane placement
  // --------------------------------------------------
  always_comb begin
    case (r_ex2_ctrl.size)
      lsu_pkg::SIZE_B: w_ex2_size_mask = 8'h01;
      lsu_pkg::SIZE_H: w_ex2_size_mask = 8'h03;
      lsu_pkg::SIZE_W: w_ex2_size_mask = 8'h0f;
      default:         w_ex2_size_mask = 8'hff;
    endcase
  end

  assign w_ex2_st_entry.addr    = {r_ex2_addr[lsu_pkg::ADDR_W-1:lsu_pkg::DW_OFS_W],
                                   {lsu_pkg::DW_OFS_W{1'b0}}};
  assign w_ex2_st_entry.byte_en = w_ex2_size_mask << r_ex2_addr[lsu_pkg::DW_OFS_W-1:0];
  assign w_ex2_st_entry.data    = r_ex2_rs2 << {r_ex2_addr[lsu_pkg::DW_OFS_W-1:0], 3'b000};
  assign w_ex2_push             = r_ex2_valid && !i_flush &&
                                  (r_ex2_ctrl.op == lsu_pkg::OP_STORE) &&
                                  (r_ex2_except == lsu_pkg::EXC_NONE);

  lsu_store_buffer #(
    .SB_DEPTH (SB_DEPTH)
  ) u_store_buffer (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_push     (w_ex2_push),
    .i_entry    (w_ex2_st_entry),
    .i_fwd_addr (r_ex2_addr),
    .o_fwd_en   (w_ex2_fwd_en),
    .o_fwd_data (w_ex2_fwd_data),
    .o_space_ok (o_issue_ready),
    .o_dm_cyc   (o_dm_cyc),
    .o_dm_stb   (o_dm_stb),
    .o_dm_we    (o_dm_we),
    .o_dm_wr    (o_dm_wr),
    .i_dm_ack   (i_dm_ack)
  );

  // --------------------------------------------------
  // EX3 reporting
  // --------------------------------------------------
  assign o_done.valid        = r_ex3_valid;
  assign o_done.cmt_id       = r_ex3_cmt_id;
  assign o_done.except_valid = (r_ex3_except != lsu_pkg::EXC_NONE);
  assign o_done.except_type  = r_ex3_except;
  assign o_done.tval         = {{(lsu_pkg::XLEN - lsu_pkg::ADDR_W){1'b0}}, r_ex3_addr};

  // x0 is never written
  assign o_rf_wr.valid = r_ex3_valid && (r_ex3_ctrl.op == lsu_pkg::OP_LOAD) &&
                         (r_ex3_except == lsu_pkg::EXC_NONE) && (r_ex3_ctrl.rd != '0);
  assign o_rf_wr.rd    = r_ex3_ctrl.rd;
  assign o_rf_wr.data  = r_ex3_data;

  lsu_fence_i_wait u_fence_i_wait (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_done_fence_i (r_ex3_valid && (r_ex3_ctrl.op == lsu_pkg::OP_FENCE_I)),
    .i_cmt_id       (r_ex3_cmt_id),
    .i_commit_valid (i_commit_valid),
    .i_commit_id    (i_commit_id),
    .o_fence_i      (o_fence_i)
  );

endmodule

// File: tb_lsu_checker.sv
`timescale 1ns/1ps

module tb_lsu_checker #(
  parameter int          SB_DEPTH = 4,
  parameter logic [31:0] BASE     = 32'h0000_1000
) (
  input logic                i_clk,
  input logic                i_reset_n,
  input lsu_pkg::lsu_issue_t i_issue,
  input logic                i_issue_ready,
  input logic                i_flush,
  input logic                i_commit_valid,
  input lsu_pkg::cmt_id_t    i_commit_id,
  input lsu_pkg::rd_req_t    i_rd_req,
  input logic                i_dm_cyc,
  input logic                i_dm_stb,
  input logic                i_dm_we,
  input logic                i_dm_ack,
  input lsu_pkg::dm_wr_t     i_dm_wr,
  input lsu_pkg::done_t      i_done,
  input lsu_pkg::rf_wr_t     i_rf_wr,
  input logic                i_fence_i
);

  typedef struct packed {
    logic               valid;
    lsu_pkg::cmt_id_t   cmt_id;
    lsu_pkg::mem_op_t   op;
    lsu_pkg::mem_size_t size;
    logic               sgn;
    lsu_pkg::addr_t     addr;
    lsu_pkg::except_t   exc;
    lsu_pkg::reg_idx_t  rd;
    lsu_pkg::xlen_t     rs2;
    lsu_pkg::xlen_t     data;
  } slot_t;

  slot_t              ex1;
  slot_t              ex2;
  slot_t              ex3;
  // Program-order memory and memory as built from drained writes
  logic [7:0]         model_mem [256];
  logic [7:0]         wb_mem [256];
  lsu_pkg::addr_t     q_adr [$];
  lsu_pkg::byte_en_t  q_sel [$];
  lsu_pkg::xlen_t     q_dat [$];
  logic               fi_wait;
  lsu_pkg::cmt_id_t   fi_id;
  logic               stb_wait;
  logic               ready_dropped;
  int                 err_value;
  int                 err_other;

  initial begin
    logic [31:0] a;
    err_value     = 0;
    err_other     = 0;
    ready_dropped = 1'b0;
    for (int i = 0; i < 256; i++) begin
      a            = BASE + 32'(i);
      model_mem[i] = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h3c;
      wb_mem[i]    = model_mem[i];
    end
  end

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    if (got !== exp) begin
      err_value++;
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic report_fail(input string what);
    err_other++;
    $display("Failure at t=%0t: %s", $time, what);
  endtask

  // Decode from the RISC-V load, store and MISC-MEM encodings
  function automatic slot_t decode(input lsu_pkg::lsu_issue_t is);
    slot_t       s;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [31:0] imm;
    logic [31:0] amask;
    s        = '0;
    opc      = is.inst[6:0];
    f3       = is.inst[14:12];
    s.valid  = 1'b1;
    s.cmt_id = is.cmt_id;
    s.size   = lsu_pkg::mem_size_t'(f3[1:0]);
    s.sgn    = !f3[2];
    s.rs2    = is.rs2_data;
    s.op     = lsu_pkg::OP_ILLEGAL;
    imm      = {{20{is.inst[31]}}, is.inst[31:20]};
    if ((opc == 7'b0000011) && (f3 != 3'b111)) begin
      s.op = lsu_pkg::OP_LOAD;
      s.rd = is.inst[11:7];
    end
    if (opc == 7'b0100011) begin
      imm = {{20{is.inst[31]}}, is.inst[31:25], is.inst[11:7]};
      if (!f3[2]) begin
        s.op = lsu_pkg::OP_STORE;
      end
    end
    if ((opc == 7'b0001111) && (f3 == 3'b000)) begin
      s.op = lsu_pkg::OP_FENCE;
    end
    if ((opc == 7'b0001111) && (f3 == 3'b001)) begin
      s.op = lsu_pkg::OP_FENCE_I;
    end
    s.addr = is.rs1_data[31:0] + imm;
    amask  = (32'd1 << f3[1:0]) - 32'd1;
    if (s.op == lsu_pkg::OP_ILLEGAL) begin
      s.exc = lsu_pkg::EXC_ILLEGAL_INST;
    end else if ((s.op == lsu_pkg::OP_LOAD) && ((s.addr & amask) != 0)) begin
      s.exc = lsu_pkg::EXC_LOAD_MISALIGN;
    end else if ((s.op == lsu_pkg::OP_STORE) && ((s.addr & amask) != 0)) begin
      s.exc = lsu_pkg::EXC_STORE_MISALIGN;
    end
    return s;
  endfunction

  function automatic lsu_pkg::xlen_t load_value(input slot_t s);
    lsu_pkg::xlen_t v;
    int             n;
    logic [31:0]    d;
    n = 1 << s.size;
    v = '0;
    d = s.addr - BASE;
    for (int k = 0; k < n; k++) begin
      v[k*8 +: 8] = model_mem[d[7:0] + 8'(k)];
    end
    if (s.sgn && (n < 8) && v[n*8-1]) begin
      v = v | ~((64'd1 << (n * 8)) - 64'd1);
    end
    return v;
  endfunction

  // --------------------------------------------------
  // Per-cycle comparison and model update
  // --------------------------------------------------
  always @(negedge i_clk) begin
    slot_t             nxt3;
    logic              exp_rf;
    logic              exp_rd;
    logic              exp_fi;
    logic [31:0]       d;
    int                lane;
    lsu_pkg::xlen_t    mask;
    lsu_pkg::xlen_t    dat;
    lsu_pkg::byte_en_t sel;
    if (!i_reset_n) begin
      ex1      = '0;
      ex2      = '0;
      ex3      = '0;
      fi_wait  = 1'b0;
      stb_wait = 1'b0;
    end else begin
      check_val("o_issue_ready", 64'(i_issue_ready), 64'((SB_DEPTH - q_adr.size()) >= 3));
      if (!i_issue_ready) begin
        ready_dropped = 1'b1;
      end
      if (q_adr.size() > SB_DEPTH) begin
        report_fail("more stores pending than the store buffer holds");
      end

      // Wishbone request lines
      if (q_adr.size() == 0) begin
        check_val("o_dm_cyc", 64'(i_dm_cyc), 64'(0));
        check_val("o_dm_stb", 64'(i_dm_stb), 64'(0));
      end
      if (stb_wait) begin
        check_val("o_dm_stb", 64'(i_dm_stb), 64'(1));
      end
      if (i_dm_stb) begin
        check_val("o_dm_cyc", 64'(i_dm_cyc), 64'(1));
        check_val("o_dm_we", 64'(i_dm_we), 64'(1));
      end
      stb_wait = i_dm_stb && !i_dm_ack;

      check_val("o_done.valid", 64'(i_done.valid), 64'(ex3.valid));
      if (ex3.valid && i_done.valid) begin
        check_val("o_done.cmt_id", 64'(i_done.cmt_id), 64'(ex3.cmt_id));
        check_val("o_done.except_valid", 64'(i_done.except_valid),
                  64'(ex3.exc != lsu_pkg::EXC_NONE));
        check_val("o_done.except_type", 64'(i_done.except_type), 64'(ex3.exc));
        check_val("o_done.tval", i_done.tval, {32'h0, ex3.addr});
      end
      exp_rf = ex3.valid && (ex3.op == lsu_pkg::OP_LOAD) &&
               (ex3.exc == lsu_pkg::EXC_NONE) && (ex3.rd != 0);
      check_val("o_rf_wr.valid", 64'(i_rf_wr.valid), 64'(exp_rf));
      if (exp_rf && i_rf_wr.valid) begin
        check_val("o_rf_wr.rd", 64'(i_rf_wr.rd), 64'(ex3.rd));
        check_val("o_rf_wr.data", i_rf_wr.data, ex3.data);
      end

      exp_fi = fi_wait && i_commit_valid && (i_commit_id == fi_id);
      check_val("o_fence_i", 64'(i_fence_i), 64'(exp_fi));
      if (exp_fi) begin
        fi_wait = 1'b0;
      end
      if (ex3.valid && (ex3.op == lsu_pkg::OP_FENCE_I)) begin
        fi_wait = 1'b1;
        fi_id   = ex3.cmt_id;
      end

      exp_rd = ex1.valid && (ex1.op == lsu_pkg::OP_LOAD) && (ex1.exc == lsu_pkg::EXC_NONE);
      check_val("o_rd_req.valid", 64'(i_rd_req.valid), 64'(exp_rd));
      if (exp_rd && i_rd_req.valid) begin
        check_val("o_rd_req.addr", 64'(i_rd_req.addr), 64'({ex1.addr[31:3], 3'b000}));
      end

      // Drained write at the coming edge, must be the oldest store
      if (i_dm_stb && i_dm_ack) begin
        if (q_adr.size() == 0) begin
          report_fail("Wishbone write with no store pending");
        end else begin
          mask = '0;
          for (int b = 0; b < 8; b++) begin
            mask[b*8 +: 8] = {8{q_sel[0][b]}};
          end
          check_val("o_dm_wr.adr", 64'(i_dm_wr.adr), 64'(q_adr[0]));
          check_val("o_dm_wr.sel", 64'(i_dm_wr.sel), 64'(q_sel[0]));
          check_val("o_dm_wr.dat", i_dm_wr.dat & mask, q_dat[0] & mask);
          d = i_dm_wr.adr - BASE;
          for (int b = 0; b < 8; b++) begin
            if (i_dm_wr.sel[b]) begin
              wb_mem[d[7:0] + 8'(b)] = i_dm_wr.dat[b*8 +: 8];
            end
          end
          q_adr.delete(0);
          q_sel.delete(0);
          q_dat.delete(0);
        end
      end

      nxt3 = '0;
      if (ex2.valid && !i_flush) begin
        nxt3 = ex2;
        if ((ex2.op == lsu_pkg::OP_LOAD) && (ex2.exc == lsu_pkg::EXC_NONE)) begin
          nxt3.data = load_value(ex2);
        end
        if ((ex2.op == lsu_pkg::OP_STORE) && (ex2.exc == lsu_pkg::EXC_NONE)) begin
          d   = ex2.addr - BASE;
          sel = '0;
          dat = '0;
          for (int k = 0; k < (1 << ex2.size); k++) begin
            lane                 = int'(ex2.addr[2:0]) + k;
            model_mem[d[7:0] + 8'(k)] = ex2.rs2[k*8 +: 8];
            sel[lane]            = 1'b1;
            dat[lane*8 +: 8]     = ex2.rs2[k*8 +: 8];
          end
          q_adr.push_back({ex2.addr[31:3], 3'b000});
          q_sel.push_back(sel);
          q_dat.push_back(dat);
        end
      end
      ex3 = nxt3;
      ex2 = (ex1.valid && !i_flush) ? ex1 : '0;
      ex1 = (i_issue.valid && i_issue_ready && !i_flush) ? decode(i_issue) : '0;
    end
  end

  task automatic final_check();
    if (q_adr.size() != 0) begin
      report_fail("stores still pending at the end of the run");
    end
    if (fi_wait) begin
      report_fail("FENCE.I still waiting for its commit at the end of the run");
    end
    if (!ready_dropped) begin
      report_fail("o_issue_ready never dropped during the run");
    end
    for (int i = 0; i < 256; i++) begin
      check_val($sformatf("memory[%h]", BASE + 32'(i)), 64'(wb_mem[i]), 64'(model_mem[i]));
    end
  endtask

endmodule

// File: tb_lsu_pipe.sv
`timescale 1ns/1ps

module tb_lsu_pipe;

  localparam int          SB_DEPTH   = 4;
  localparam int          N_OPS      = 2000;
  localparam int          MAX_CYCLES = N_OPS * 20;
  localparam logic [31:0] BASE       = 32'h0000_1000;

  logic                clk;
  logic                reset_n;
  lsu_pkg::lsu_issue_t issue;
  logic                issue_ready;
  logic                flush;
  logic                commit_valid;
  lsu_pkg::cmt_id_t    commit_id;
  lsu_pkg::rd_req_t    rd_req;
  lsu_pkg::xlen_t      rd_data;
  logic                dm_cyc;
  logic                dm_stb;
  logic                dm_we;
  lsu_pkg::dm_wr_t     dm_wr;
  logic                dm_ack;
  lsu_pkg::done_t      done;
  lsu_pkg::rf_wr_t     rf_wr;
  logic                fence_i;

  // Memory window seen by the read port and the Wishbone port
  logic [7:0]       mem [256];
  int               cyc = 0;
  int               ack_wait;
  logic             s_ack_fire;
  lsu_pkg::dm_wr_t  s_dm_wr;
  lsu_pkg::rd_req_t s_rd_req;
  int               due_q [$];
  lsu_pkg::cmt_id_t id_q [$];

  lsu_pipe #(
    .SB_DEPTH (SB_DEPTH)
  ) uut (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_issue        (issue),
    .o_issue_ready  (issue_ready),
    .i_flush        (flush),
    .i_commit_valid (commit_valid),
    .i_commit_id    (commit_id),
    .o_rd_req       (rd_req),
    .i_rd_data      (rd_data),
    .o_dm_cyc       (dm_cyc),
    .o_dm_stb       (dm_stb),
    .o_dm_we        (dm_we),
    .o_dm_wr        (dm_wr),
    .i_dm_ack       (dm_ack),
    .o_done         (done),
    .o_rf_wr        (rf_wr),
    .o_fence_i      (fence_i)
  );

  tb_lsu_checker #(
    .SB_DEPTH (SB_DEPTH),
    .BASE     (BASE)
  ) chk (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_issue        (issue),
    .i_issue_ready  (issue_ready),
    .i_flush        (flush),
    .i_commit_valid (commit_valid),
    .i_commit_id    (commit_id),
    .i_rd_req       (rd_req),
    .i_dm_cyc       (dm_cyc),
    .i_dm_stb       (dm_stb),
    .i_dm_we        (dm_we),
    .i_dm_ack       (dm_ack),
    .i_dm_wr        (dm_wr),
    .i_done         (done),
    .i_rf_wr        (rf_wr),
    .i_fence_i      (fence_i)
  );

  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h3c;
  endfunction

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  always @(posedge clk) begin
    if (cyc >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Error counts: %0d wrong values, %0d other failures",
               chk.err_value, chk.err_other);
      $display("Done: errors found");
      $finish;
    end
  end

  // --------------------------------------------------
  // Memory and commit responders
  // --------------------------------------------------
  // Snapshot mid-cycle so the edge processes see settled values
  always @(negedge clk) begin
    s_ack_fire = dm_stb && dm_ack;
    s_dm_wr    = dm_wr;
    s_rd_req   = rd_req;
    if (reset_n && done.valid) begin
      id_q.push_back(done.cmt_id);
      due_q.push_back(cyc + 1 + int'($urandom % 3));
    end
  end

  always @(posedge clk) begin
    logic [31:0] diff;
    #1;
    if (s_ack_fire) begin
      diff = s_dm_wr.adr - BASE;
      for (int b = 0; b < 8; b++) begin
        if (s_dm_wr.sel[b]) begin
          mem[diff[7:0] + 8'(b)] = s_dm_wr.dat[b*8 +: 8];
        end
      end
      ack_wait = int'($urandom_range(3, 0));
    end
    if (s_rd_req.valid) begin
      diff = s_rd_req.addr - BASE;
      for (int b = 0; b < 8; b++) begin
        rd_data[b*8 +: 8] = mem[diff[7:0] + 8'(b)];
      end
    end
    if (dm_stb && (ack_wait == 0)) begin
      dm_ack = 1'b1;
    end else begin
      dm_ack = 1'b0;
      if (dm_stb) begin
        ack_wait--;
      end
    end
    commit_valid = 1'b0;
    if ((id_q.size() > 0) && (due_q[0] <= cyc)) begin
      commit_valid = 1'b1;
      commit_id    = id_q.pop_front();
      due_q.delete(0);
    end
  end

  // --------------------------------------------------
  // Random operation generator
  // --------------------------------------------------
  task automatic make_op(input logic allow_fi, output lsu_pkg::inst_t inst,
                         output lsu_pkg::xlen_t rs1, output lsu_pkg::xlen_t rs2);
    int          kind;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [7:0]  ofs;
    logic [4:0]  rd;
    logic [4:0]  rsf;
    kind = int'($urandom % 100);
    f3   = 3'($urandom % 7);
    imm  = 12'($urandom_range(31, 0)) - 12'd16;
    ofs  = 8'($urandom);
    rd   = 5'($urandom);
    rsf  = 5'($urandom);
    // Mostly aligned to the access size
    if (($urandom % 8) != 0) begin
      ofs = ofs & ~((8'd1 << f3[1:0]) - 8'd1);
    end
    rs1 = {32'h0, BASE + {24'h0, ofs} - {{20{imm[11]}}, imm}};
    rs2 = {$urandom, $urandom};
    if (kind < 45) begin
      inst = {imm, rsf, f3, rd, 7'b0000011};
    end else if (kind < 85) begin
      inst = {imm[11:5], rd, rsf, 1'b0, f3[1:0], imm[4:0], 7'b0100011};
    end else if (kind < 90) begin
      inst = {imm, rsf, 3'b000, rd, 7'b0001111};
    end else if ((kind < 94) && allow_fi) begin
      inst = {imm, rsf, 3'b001, rd, 7'b0001111};
    end else begin
      case ($urandom % 3)
        0:       inst = {imm, rsf, f3, rd, 7'b0110011};
        1:       inst = {imm, rsf, 3'b111, rd, 7'b0000011};
        default: inst = {imm[11:5], rd, rsf, 1'b1, f3[1:0], imm[4:0], 7'b0100011};
      endcase
    end
  endtask

  initial begin
    int               n_acc;
    int               last_fi;
    lsu_pkg::cmt_id_t next_id;
    void'($urandom(32'ha0c26b05));
    reset_n      = 1'b0;
    issue        = '0;
    flush        = 1'b0;
    commit_valid = 1'b0;
    commit_id    = '0;
    rd_data      = '0;
    dm_ack       = 1'b0;
    ack_wait     = 0;
    n_acc        = 0;
    last_fi      = -100;
    next_id      = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_byte(BASE + 32'(i));
    end
    repeat (5) @(posedge clk);
    #1;
    reset_n = 1'b1;

    while (n_acc < N_OPS) begin
      @(posedge clk);
      #1;
      issue.valid  = (($urandom % 5) != 0);
      issue.cmt_id = next_id;
      make_op((cyc - last_fi) >= 12, issue.inst, issue.rs1_data, issue.rs2_data);
      flush = (($urandom % 32) == 0);
      if (issue.valid && issue_ready) begin
        n_acc++;
        next_id++;
        if ((issue.inst[6:0] == 7'b0001111) && (issue.inst[14:12] == 3'b001)) begin
          last_fi = cyc;
        end
      end
    end

    @(posedge clk);
    #1;
    issue.valid = 1'b0;
    flush       = 1'b0;
    repeat (6) @(posedge clk);
    while (dm_cyc || (id_q.size() != 0)) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    chk.final_check();
    $display("Error counts: %0d wrong values, %0d other failures",
             chk.err_value, chk.err_other);
    if ((chk.err_value + chk.err_other) == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: all.f
lsu_pkg.sv
lsu_decoder.sv
lsu_agu.sv
lsu_load_align.sv
lsu_store_buffer.sv
lsu_fence_i_wait.sv
lsu_pipe.sv
tb_lsu_checker.sv
tb_lsu_pipe.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_lsu_pipe
FILELIST  ?= all.f
LOG       ?= sim.log
PASS_MSG  := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
